//--- bench/umi_ram_stimulus.txt
// columns: opcode dstaddr srcaddr wdata expected_read_data (all hex)
// 03 posted write, 01 read, other opcodes are dropped, ff ends the list
03 10               0                deadbeef         0
01 10               cafe0001         0                deadbeef
03 20               0                12345678         0
03 120              0                87654321         0
01 20               cafe0002         0                87654321
01 ffff000000000020 cafe0003         0                87654321
07 20               0                ffffffff         0
01 20               cafe0004         0                87654321
03 30               0                aaaaaaaa5555aaaa 0
01 130              12340000beef0005 0                5555aaaa
03 40               0                00000001         0
03 41               0                00000002         0
03 42               0                00000003         0
01 40               6                0                00000001
01 41               7                0                00000002
01 42               8                0                00000003
01 10               9                0                deadbeef
03 10               0                0badf00d         0
01 10               a                0                0badf00d
01 30               b                0                5555aaaa
01 41               c                0                00000002
01 42               d                0                00000003
00 50               0                11111111         0
01 10               e                0                0badf00d
ff 0                0                0                0

//--- vlog.f
hdl/umi_pkg.sv
hdl/umi_unpack.sv
hdl/umi_pack.sv
hdl/umi_queue.sv
hdl/umi_ram.sv
hdl/umi_ram_top.sv
bench/umi_ram_asserts.sv
bench/umi_ram_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module umi_ram_tb -f vlog.f -o umi_ram_sim

# the pipeline status is the status of grep
./obj_dir/umi_ram_sim | tee /dev/stderr | grep "STATUS: PASS" > /dev/null
echo "simulation passed"

//--- bench/umi_ram_tb.sv
`timescale 1ns/1ps

module umi_ram_tb;

    localparam int ram_addr_w = 8;
    localparam int max_lines = 64;
    localparam int wait_limit = 400;

    logic clk;
    logic reset;
    umi_pkg::umi_packet_t rx_packet;
    logic rx_valid;
    logic rx_ready;
    umi_pkg::umi_packet_t tx_packet;
    logic tx_valid;
    logic tx_ready;

    // five words per line: opcode, dstaddr, srcaddr, wdata, expected
    logic [63:0] stim [5*max_lines];
    logic [umi_pkg::ram_data_w-1:0] model [2**ram_addr_w];

    // reads in request order
    logic [63:0] exp_dst [$];
    logic [63:0] exp_data [$];

    integer seed;
    int num_lines;
    int num_reads;
    int num_responses;
    logic saw_stall;

    umi_ram_top #(
        .addr_w(ram_addr_w)
    ) dut0 (
        .clk(clk),
        .reset(reset),
        .rx_packet(rx_packet),
        .rx_valid(rx_valid),
        .rx_ready(rx_ready),
        .tx_packet(tx_packet),
        .tx_valid(tx_valid),
        .tx_ready(tx_ready)
    );

    initial clk = 1'b0;
    always #2 clk = ~clk;

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("STATUS: FAIL");
        $fatal(1, "run aborted");
    endtask

    task automatic check_value(input string name, input logic [63:0] expected,
                               input logic [63:0] actual);
        if (actual !== expected) begin
            $display("Mismatch %s expected %h actual %h", name, expected, actual);
            $display("STATUS: FAIL");
            $fatal(1, "value check failed");
        end
    endtask

    // mostly low, so the response path backs up
    function automatic logic next_ready();
        return (($random(seed) & 3) == 0);
    endfunction

    // walk the file up to the end marker, cross-check reads against the model
    task automatic load_stimulus();
        int i;
        logic found;
        logic [7:0] opcode;
        logic [ram_addr_w-1:0] index;
        $readmemh("bench/umi_ram_stimulus.txt", stim);
        i = 0;
        found = 1'b0;
        while (i < max_lines && !found) begin
            opcode = stim[5*i][7:0];
            if (opcode == 8'hff) begin
                found = 1'b1;
            end else begin
                index = stim[5*i+1][ram_addr_w-1:0];
                if (opcode == umi_pkg::opc_write_posted) begin
                    model[index] = stim[5*i+3][umi_pkg::ram_data_w-1:0];
                end else if (opcode == umi_pkg::opc_read) begin
                    check_value($sformatf("line %0d file vs model", i),
                                stim[5*i+4], 64'(model[index]));
                    exp_dst.push_back(stim[5*i+2]);
                    exp_data.push_back(stim[5*i+4]);
                end
                i++;
            end
        end
        if (!found || i == 0) begin
            abort_run("stimulus file holds no transactions or lacks the end marker");
        end
        num_lines = i;
        num_reads = exp_dst.size();
    endtask

    // called at a falling edge, returns at the falling edge after the transfer
    task automatic send_request(input int i);
        int waited;
        rx_packet = '0;
        rx_packet.cmd.opcode = stim[5*i][7:0];
        rx_packet.cmd.size = umi_pkg::ram_size;
        rx_packet.dstaddr = stim[5*i+1];
        rx_packet.srcaddr = stim[5*i+2];
        rx_packet.data = stim[5*i+3];
        rx_valid = 1'b1;
        waited = 0;
        while (!rx_ready) begin
            saw_stall = 1'b1;
            @(negedge clk);
            waited++;
            if (waited > wait_limit) begin
                abort_run($sformatf("timeout waiting for rx_ready on line %0d", i));
            end
        end
        // taken on the coming rising edge
        @(negedge clk);
        rx_valid = 1'b0;
    endtask

    task automatic receive_response(input int n);
        int waited;
        string name;
        waited = 0;
        @(negedge clk);
        tx_ready = next_ready();
        while (!(tx_valid && tx_ready)) begin
            waited++;
            if (waited > wait_limit) begin
                abort_run($sformatf("timeout waiting for response %0d on tx", n));
            end
            @(negedge clk);
            tx_ready = next_ready();
        end
        name = $sformatf("response %0d", n);
        check_value({name, " opcode"}, 64'(umi_pkg::opc_read_resp), 64'(tx_packet.cmd.opcode));
        check_value({name, " size"}, 64'(umi_pkg::ram_size), 64'(tx_packet.cmd.size));
        check_value({name, " user"}, 64'(0), 64'(tx_packet.cmd.user));
        check_value({name, " reserved"}, 64'(0), 64'(tx_packet.reserved));
        check_value({name, " dstaddr"}, exp_dst[n], tx_packet.dstaddr);
        check_value({name, " srcaddr"}, 64'(0), tx_packet.srcaddr);
        check_value({name, " data"}, exp_data[n], tx_packet.data);
        num_responses++;
    endtask

    initial begin
        int i;
        int n;
        seed = 42;
        reset = 1'b1;
        rx_valid = 1'b0;
        rx_packet = '0;
        tx_ready = 1'b0;
        saw_stall = 1'b0;
        num_responses = 0;
        load_stimulus();
        repeat (10) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        @(negedge clk);
        check_value("rx_ready after reset", 64'(1), 64'(rx_ready));
        check_value("tx_valid after reset", 64'(0), 64'(tx_valid));
        fork
            begin
                for (i = 0; i < num_lines; i++) begin
                    send_request(i);
                end
            end
            begin
                for (n = 0; n < num_reads; n++) begin
                    receive_response(n);
                end
            end
        join
        // quiet window, any further packet is an extra response
        tx_ready = 1'b1;
        repeat (20) begin
            @(negedge clk);
            if (tx_valid) begin
                num_responses++;
            end
        end
        check_value("response count", 64'(num_reads), 64'(num_responses));
        check_value("rx_ready fell under back-pressure", 64'(1), 64'(saw_stall));
        $display("STATUS: PASS");
        $finish;
    end

endmodule

//--- bench/umi_ram_asserts.sv
`timescale 1ns/1ps

module umi_ram_asserts (
    input logic clk,
    input logic reset,
    input umi_pkg::umi_packet_t tx_packet,
    input logic tx_valid,
    input logic tx_ready
);

    // a stalled response holds until taken
    tx_stable: assert property (@(posedge clk) disable iff (reset)
        tx_valid && !tx_ready |=> tx_valid && $stable(tx_packet))
        else $error("tx stream changed while tx_ready was low");

    tx_idle_in_reset: assert property (@(posedge clk) reset |=> !tx_valid)
        else $error("tx_valid high during reset");

    tx_opcode: assert property (@(posedge clk) disable iff (reset)
        tx_valid && tx_ready |-> tx_packet.cmd.opcode == umi_pkg::opc_read_resp)
        else $error("sent packet without the read response opcode");

endmodule

bind umi_ram_top umi_ram_asserts asserts0 (
    .clk(clk),
    .reset(reset),
    .tx_packet(tx_packet),
    .tx_valid(tx_valid),
    .tx_ready(tx_ready)
);

//--- hdl/umi_ram_top.sv
`timescale 1ns/1ps

module umi_ram_top #(
    parameter int addr_w = 8
) (
    input logic clk,
    input logic reset,
    input umi_pkg::umi_packet_t rx_packet,
    input logic rx_valid,
    output logic rx_ready,
    output umi_pkg::umi_packet_t tx_packet,
    output logic tx_valid,
    input logic tx_ready
);

    // unpack to request queue
    umi_pkg::umi_req_t dec_req;
    logic dec_valid;
    logic dec_ready;

    // request queue to ram
    umi_pkg::umi_req_t ram_req;
    logic ram_req_valid;
    logic ram_req_ready;

    // ram to pack
    umi_pkg::umi_resp_t ram_resp;
    logic ram_resp_valid;
    logic ram_resp_ready;

    // pack to response queue
    umi_pkg::umi_packet_t resp_packet;
    logic resp_packet_valid;
    logic resp_packet_ready;

    umi_unpack unpack0 (
        .packet_in(rx_packet),
        .valid_in(rx_valid),
        .ready_in(rx_ready),
        .req(dec_req),
        .req_valid(dec_valid),
        .req_ready(dec_ready)
    );

    umi_queue #(
        .item_t(umi_pkg::umi_req_t)
    ) req_queue0 (
        .clk(clk),
        .reset(reset),
        .in_item(dec_req),
        .in_valid(dec_valid),
        .in_ready(dec_ready),
        .out_item(ram_req),
        .out_valid(ram_req_valid),
        .out_ready(ram_req_ready)
    );

    umi_ram #(
        .addr_w(addr_w)
    ) ram0 (
        .clk(clk),
        .reset(reset),
        .req(ram_req),
        .req_valid(ram_req_valid),
        .req_ready(ram_req_ready),
        .resp(ram_resp),
        .resp_valid(ram_resp_valid),
        .resp_ready(ram_resp_ready)
    );

    umi_pack pack0 (
        .resp(ram_resp),
        .resp_valid(ram_resp_valid),
        .resp_ready(ram_resp_ready),
        .packet_out(resp_packet),
        .packet_valid(resp_packet_valid),
        .packet_ready(resp_packet_ready)
    );

    umi_queue #(
        .item_t(umi_pkg::umi_packet_t)
    ) resp_queue0 (
        .clk(clk),
        .reset(reset),
        .in_item(resp_packet),
        .in_valid(resp_packet_valid),
        .in_ready(resp_packet_ready),
        .out_item(tx_packet),
        .out_valid(tx_valid),
        .out_ready(tx_ready)
    );

endmodule

//--- hdl/umi_ram.sv
`timescale 1ns/1ps

module umi_ram #(
    parameter int addr_w = 8
) (
    input logic clk,
    input logic reset,
    input umi_pkg::umi_req_t req,
    input logic req_valid,
    output logic req_ready,
    output umi_pkg::umi_resp_t resp,
    output logic resp_valid,
    input logic resp_ready
);

    logic [umi_pkg::ram_data_w-1:0] mem [2**addr_w];

    logic [addr_w-1:0] index;
    logic accept;
    logic do_write;
    logic do_read;

    // upper address bits are ignored, so addresses wrap
    assign index = req.dstaddr[addr_w-1:0];

    // a read needs a free response slot, anything else goes straight in
    assign req_ready = !(req.is_read && resp_valid);

    assign accept = req_valid && req_ready;
    assign do_write = accept && req.is_write;
    assign do_read = accept && req.is_read;

    // requests with neither flag are just consumed

    always_ff @(posedge clk) begin
        if (do_write) begin
            mem[index] <= req.data;
        end
    end

    // response payload, loaded on a read
    always_ff @(posedge clk) begin
        if (do_read) begin
            resp.dstaddr <= req.srcaddr;
            resp.data <= mem[index];
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            resp_valid <= 1'b0;
        end else if (do_read) begin
            resp_valid <= 1'b1;
        end else if (resp_valid && resp_ready) begin
            resp_valid <= 1'b0;
        end
    end

endmodule

//--- hdl/umi_queue.sv
`timescale 1ns/1ps

module umi_queue #(
    parameter type item_t = logic
) (
    input logic clk,
    input logic reset,
    input item_t in_item,
    input logic in_valid,
    output logic in_ready,
    output item_t out_item,
    output logic out_valid,
    input logic out_ready
);

    item_t entries [umi_pkg::queue_depth];

    logic [$clog2(umi_pkg::queue_depth)-1:0] wr_ptr;
    logic [$clog2(umi_pkg::queue_depth)-1:0] rd_ptr;
    logic [$clog2(umi_pkg::queue_depth+1)-1:0] count;

    logic push;
    logic pop;

    // ready only looks at the fill level
    assign in_ready = (count != umi_pkg::queue_depth);
    assign out_valid = (count != 0);
    assign out_item = entries[rd_ptr];

    assign push = in_valid && in_ready;
    assign pop = out_valid && out_ready;

    // item storage
    always_ff @(posedge clk) begin
        if (push) begin
            entries[wr_ptr] <= in_item;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count <= '0;
        end else begin
            if (push) begin
                wr_ptr <= (wr_ptr == umi_pkg::queue_depth - 1) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == umi_pkg::queue_depth - 1) ? '0 : rd_ptr + 1'b1;
            end
            // push and pop together leave the count alone
            if (push && !pop) begin
                count <= count + 1'b1;
            end else if (pop && !push) begin
                count <= count - 1'b1;
            end
        end
    end

endmodule

//--- hdl/umi_pack.sv
`timescale 1ns/1ps

module umi_pack (
    input umi_pkg::umi_resp_t resp,
    input logic resp_valid,
    output logic resp_ready,
    output umi_pkg::umi_packet_t packet_out,
    output logic packet_valid,
    input logic packet_ready
);

    always_comb begin
        packet_out = '0;
        packet_out.cmd.opcode = umi_pkg::opc_read_resp;
        packet_out.cmd.size = umi_pkg::ram_size;
        packet_out.cmd.user = '0;
        packet_out.dstaddr = resp.dstaddr;
        // response carries no source address
        packet_out.srcaddr = '0;
        // zero-extend the word into the 64-bit data field
        packet_out.data = {{(64 - umi_pkg::ram_data_w){1'b0}}, resp.data};
    end

    assign packet_valid = resp_valid;
    assign resp_ready = packet_ready;

endmodule

//--- hdl/umi_unpack.sv
`timescale 1ns/1ps

module umi_unpack (
    input umi_pkg::umi_packet_t packet_in,
    input logic valid_in,
    output logic ready_in,
    output umi_pkg::umi_req_t req,
    output logic req_valid,
    input logic req_ready
);

    umi_pkg::umi_cmd_t cmd;

    assign cmd = packet_in.cmd;

    // field decode
    always_comb begin
        req = '0;
        req.is_read = (cmd.opcode == umi_pkg::opc_read);
        req.is_write = (cmd.opcode == umi_pkg::opc_write_posted);
        req.dstaddr = packet_in.dstaddr;
        req.srcaddr = packet_in.srcaddr;
        // only the low word is stored
        req.data = packet_in.data[umi_pkg::ram_data_w-1:0];
    end

    // no storage here, handshake is passed through
    assign req_valid = valid_in;
    assign ready_in = req_ready;

endmodule

//--- hdl/umi_pkg.sv
package umi_pkg;

    // opcodes seen on the wire
    localparam logic [7:0] opc_read = 8'h01;
    localparam logic [7:0] opc_read_resp = 8'h02;
    localparam logic [7:0] opc_write_posted = 8'h03;

    // one ram word per access
    localparam int ram_data_w = 32;

    // log2 of the bytes moved, 4 bytes
    localparam logic [3:0] ram_size = 4'd2;

    // entries per stream buffer
    localparam int queue_depth = 2;

    typedef struct packed {
        logic [7:0] opcode;
        logic [3:0] size;
        logic [19:0] user;
    } umi_cmd_t;

    // 256-bit packet, command in the top word
    typedef struct packed {
        umi_cmd_t cmd;
        logic [31:0] reserved;
        logic [63:0] dstaddr;
        logic [63:0] srcaddr;
        logic [63:0] data;
    } umi_packet_t;

    // decoded request as seen by the ram
    typedef struct packed {
        logic is_read;
        logic is_write;
        logic [63:0] dstaddr;
        logic [63:0] srcaddr;
        logic [ram_data_w-1:0] data;
    } umi_req_t;

    // read response, dstaddr is the requester's srcaddr
    typedef struct packed {
        logic [63:0] dstaddr;
        logic [ram_data_w-1:0] data;
    } umi_resp_t;

endpackage
